//--- verilog.f
rtl/agc_bus_pkg.sv
rtl/agc_loop_pkg.sv
rtl/agc_loop_sequencer.sv
rtl/agc_info_regs.sv
rtl/agc_step_calc.sv
rtl/agc_status_slave.sv
rtl/agc_loop_top.sv
testbench/agc_block_model.sv
testbench/tb_agc_loop.sv

//--- Bender.yml
package:
  name: agc_loop

sources:
  - rtl/agc_bus_pkg.sv
  - rtl/agc_loop_pkg.sv
  - rtl/agc_loop_sequencer.sv
  - rtl/agc_info_regs.sv
  - rtl/agc_step_calc.sv
  - rtl/agc_status_slave.sv
  - rtl/agc_loop_top.sv
  - target: test
    files:
      - testbench/agc_block_model.sv
      - testbench/tb_agc_loop.sv

//--- testbench/tb_agc_loop.sv
`timescale 1ns/1ps

module tb_agc_loop;

    // One loop iteration per row
    typedef struct packed {
        logic [31:0] power;
        logic [31:0] above;
        logic [31:0] below;
        logic [3:0]  max_polls;
        logic [31:0] exp_scale;
        logic [31:0] exp_offset;   // As written on the bus
    } row_t;

    logic                 wb_clk;
    logic                 arst_n;
    agc_bus_pkg::wb_req_t agc_req;
    agc_bus_pkg::wb_rsp_t agc_rsp;
    agc_bus_pkg::wb_req_t host_req;
    agc_bus_pkg::wb_rsp_t host_rsp;
    logic [31:0]          power;
    logic [31:0]          above;
    logic [31:0]          below;
    int unsigned          polls;
    int unsigned          row_polls;
    row_t                 rows [9];
    int                   ptr;
    logic [31:0]          rdata;

    agc_loop_top DUT (
        .wb_clk_i   (wb_clk),
        .arst_n_i   (arst_n),
        .agc_req_o  (agc_req),
        .agc_rsp_i  (agc_rsp),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp)
    );

    agc_block_model u_agc_block (
        .wb_clk_i (wb_clk),
        .arst_n_i (arst_n),
        .req_i    (agc_req),
        .rsp_o    (agc_rsp),
        .power_i  (power),
        .above_i  (above),
        .below_i  (below),
        .polls_i  (polls)
    );

    initial begin
        wb_clk = 1'b0;
        forever #50 wb_clk = ~wb_clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic stop_with_fail(input string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERROR @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_with_fail({what, " mismatch"});
        end
    endtask

    task automatic wait_log(input int count);
        int cycles;
        cycles = 0;
        while (u_agc_block.log_q.size() < count) begin
            @(posedge wb_clk);
            #10;
            cycles++;
            if (cycles > 2000)
                stop_with_fail("timed out waiting for AGC bus transactions");
        end
    endtask

    task automatic check_txn(input int idx, input logic we, input logic [7:0] adr,
                             input logic [31:0] dat);
        agc_bus_pkg::wb_req_t txn;
        txn = u_agc_block.log_q[idx];
        check_equal(32'(txn.we), 32'(we), $sformatf("transaction %0d write flag", idx));
        check_equal(32'(txn.adr), 32'(adr), $sformatf("transaction %0d address", idx));
        check_equal(32'(txn.sel), 32'hf, $sformatf("transaction %0d byte select", idx));
        if (we)
            check_equal(txn.dat, dat, $sformatf("transaction %0d data", idx));
    endtask

    task automatic host_read(input logic [7:0] adr, output logic [31:0] dat);
        int edges;
        edges    = 0;
        host_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0, sel: 4'hf};
        while (!host_rsp.ack) begin
            @(posedge wb_clk);
            #10;
            edges++;
            if (edges > 20)
                stop_with_fail("host read was never acknowledged");
        end
        // Ack lands in the third cycle of the request
        check_equal(32'(edges), 32'd2, $sformatf("ack latency of host read %h", adr));
        dat      = host_rsp.dat;
        host_req = '0;
        @(posedge wb_clk);                           // Slave back in idle
        #10;
    endtask

    task automatic apply_row(input int r);
        power = rows[r].power;
        above = rows[r].above;
        below = rows[r].below;
        polls = $urandom % (rows[r].max_polls + 1);
    endtask

    // Power, above, below, max polls, scale and offset expected on the bus
    task automatic fill_table();
        rows[0] = '{32'h0002_0000, 32'd10,  32'd10,  4'd0, 32'd1800, 32'd0};  // On target
        rows[1] = '{32'h0004_0000, 32'd20,  32'd10,  4'd3, 32'd1770, -32'sd25};
        rows[2] = '{32'h0000_1000, 32'd10,  32'd20,  4'd1, 32'd1800, 32'd0};
        rows[3] = '{32'h0010_0000, 32'd40,  32'd45,  4'd5, 32'd1770, 32'd0};  // Within tolerance
        rows[4] = '{32'h0002_1fff, 32'd50,  32'd44,  4'd2, 32'd1770, -32'sd25};
        rows[5] = '{32'h0003_e000, 32'd3,   32'd9,   4'd4, 32'd1740, 32'd0};
        rows[6] = '{32'h0001_e000, 32'd100, 32'd0,   4'd0, 32'd1770, -32'sd25};
        rows[7] = '{32'h0100_0000, 32'd100, 32'd0,   4'd2, 32'd1740, -32'sd50};
        rows[8] = '{32'h0200_0000, 32'd0,   32'd100, 4'd1, 32'd1770, -32'sd25}; // Bit 25 dropped
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'hef59_732f));
        arst_n    = 1'b0;
        host_req  = '0;
        power     = '0;
        above     = '0;
        below     = '0;
        polls     = 0;
        row_polls = 0;
        ptr       = 0;
        fill_table();
        repeat (2) @(posedge wb_clk);
        #10;
        arst_n = 1'b1;

        // Master stays quiet through boot
        for (int i = 0; i <= agc_loop_pkg::BOOT_CYCLES; i++) begin
            @(posedge wb_clk);
            #10;
            check_equal(32'(agc_req.cyc), 32'd0, "cyc during boot");
        end

        wait_log(4);
        check_txn(0, 1'b1, 8'h10, 32'd1800);
        check_txn(1, 1'b1, 8'h14, 32'd0);
        check_txn(2, 1'b1, 8'h00, 32'h0000_0300);
        check_txn(3, 1'b1, 8'h00, 32'h0000_0400);
        ptr = 4;

        apply_row(0);
        foreach (rows[r]) begin
            row_polls = polls;
            wait_log(ptr + 13 + row_polls);
            // Next row must reach the model before its first poll
            if (r + 1 < $size(rows))
                apply_row(r + 1);
            host_read(8'h01, rdata);                 // Before the next power read lands
            check_equal(rdata, rows[r].power, $sformatf("row %0d host power word", r));
            host_read(8'h04, rdata);                 // Applied scale copied on commit
            check_equal(rdata, rows[r].exp_scale, $sformatf("row %0d host scale word", r));
            host_read(8'h05, rdata);
            check_equal(rdata, rows[r].exp_offset, $sformatf("row %0d host offset word", r));

            check_txn(ptr, 1'b1, 8'h00, 32'h0000_0004);
            check_txn(ptr + 1, 1'b1, 8'h00, 32'h0000_0001);
            ptr += 2;
            for (int p = 0; p <= row_polls; p++) begin
                check_txn(ptr + p, 1'b0, 8'h00, '0);
            end
            ptr += row_polls + 1;
            for (int k = 0; k < 6; k++) begin
                check_txn(ptr + k, 1'b0, 8'(4 * k), '0);
            end
            ptr += 6;
            check_txn(ptr, 1'b1, 8'h10, rows[r].exp_scale);
            check_txn(ptr + 1, 1'b1, 8'h14, rows[r].exp_offset);
            check_txn(ptr + 2, 1'b1, 8'h00, 32'h0000_0300);
            check_txn(ptr + 3, 1'b1, 8'h00, 32'h0000_0400);
            ptr += 4;

            host_read(8'h10, rdata);
            check_equal(rdata, 32'd30, "host scale step");
            host_read(8'h11, rdata);
            check_equal(rdata, 32'd25, "host offset step");
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- testbench/agc_block_model.sv
`timescale 1ns/1ps

module agc_block_model (
    input  logic                 wb_clk_i,
    input  logic                 arst_n_i,
    input  agc_bus_pkg::wb_req_t req_i,
    output agc_bus_pkg::wb_rsp_t rsp_o,
    input  logic [31:0]          power_i,
    input  logic [31:0]          above_i,
    input  logic [31:0]          below_i,
    input  int unsigned          polls_i     // Not-done polls before done
);

    agc_bus_pkg::wb_req_t log_q[$];          // Every transaction, reads hold returned data
    logic [31:0]          scale_q;           // Echo of the last scale written
    logic [31:0]          offset_q;
    int unsigned          poll_cnt;
    int unsigned          delay;
    logic                 busy;

    // Answer one request and record it
    task automatic serve(input agc_bus_pkg::wb_req_t req);
        agc_bus_pkg::wb_req_t entry;
        entry = req;
        rsp_o.dat = '0;
        if (req.we) begin
            if (req.adr == agc_bus_pkg::ADR_SCALE)
                scale_q = req.dat;
            if (req.adr == agc_bus_pkg::ADR_SCALE + 8'd4)
                offset_q = req.dat;
            // A new measurement starts with a fresh poll count
            if (req.adr == agc_bus_pkg::ADR_CTRL && req.dat == agc_bus_pkg::CMD_START)
                poll_cnt = 0;
        end else begin
            case (req.adr)
                8'h00: begin
                    if (poll_cnt < polls_i) begin
                        poll_cnt++;                  // Still measuring
                    end else begin
                        rsp_o.dat = 32'd1 << agc_bus_pkg::STATUS_DONE_BIT;
                    end
                end
                8'h04:   rsp_o.dat = power_i;
                8'h08:   rsp_o.dat = above_i;
                8'h0c:   rsp_o.dat = below_i;
                8'h10:   rsp_o.dat = scale_q;
                8'h14:   rsp_o.dat = offset_q;
                default: rsp_o.dat = '0;
            endcase
            entry.dat = rsp_o.dat;
        end
        log_q.push_back(entry);
    endtask

    initial begin
        rsp_o    = '0;
        scale_q  = '0;
        offset_q = '0;
        poll_cnt = 0;
        delay    = 0;
        busy     = 1'b0;
        forever begin
            @(posedge wb_clk_i);
            #10;
            if (!arst_n_i || rsp_o.ack) begin
                rsp_o.ack = 1'b0;                    // Ack lasts one cycle
            end else if (req_i.cyc && req_i.stb) begin
                if (!busy) begin
                    busy  = 1'b1;
                    delay = $urandom % 4;            // Back-pressure of 0 to 3 cycles
                end
                if (delay == 0) begin
                    serve(req_i);
                    rsp_o.ack = 1'b1;
                    busy      = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

endmodule

//--- rtl/agc_loop_top.sv
`timescale 1ns/1ps

module agc_loop_top (
    input  logic                 wb_clk_i,
    input  logic                 arst_n_i,
    output agc_bus_pkg::wb_req_t agc_req_o,
    input  agc_bus_pkg::wb_rsp_t agc_rsp_i,
    input  agc_bus_pkg::wb_req_t host_req_i,
    output agc_bus_pkg::wb_rsp_t host_rsp_o
);

    logic                      info_we;
    agc_loop_pkg::info_idx_t   info_idx;
    logic [31:0]               info_dat;
    logic                      calc;
    logic                      commit;
    agc_loop_pkg::scale_t      new_scale;
    agc_loop_pkg::offset_t     new_offset;
    agc_loop_pkg::info_words_t info_words;
    agc_loop_pkg::power_adj_t  power_adj;
    logic [3:0]                rd_idx;
    logic [31:0]               rd_dat;

    agc_loop_sequencer u_sequencer (
        .wb_clk_i     (wb_clk_i),
        .arst_n_i     (arst_n_i),
        .agc_req_o    (agc_req_o),
        .agc_rsp_i    (agc_rsp_i),
        .info_we_o    (info_we),
        .info_idx_o   (info_idx),
        .info_dat_o   (info_dat),
        .calc_o       (calc),
        .commit_o     (commit),
        .new_scale_i  (new_scale),
        .new_offset_i (new_offset)
    );

    agc_info_regs u_info_regs (
        .wb_clk_i    (wb_clk_i),
        .arst_n_i    (arst_n_i),
        .info_we_i   (info_we),
        .info_idx_i  (info_idx),
        .info_dat_i  (info_dat),
        .commit_i    (commit),
        .scale_i     (new_scale),
        .offset_i    (new_offset),
        .rd_idx_i    (rd_idx),
        .rd_dat_o    (rd_dat),
        .info_o      (info_words),
        .power_adj_o (power_adj)
    );

    agc_step_calc u_step_calc (
        .wb_clk_i    (wb_clk_i),
        .arst_n_i    (arst_n_i),
        .calc_i      (calc),
        .info_i      (info_words),
        .power_adj_i (power_adj),
        .scale_o     (new_scale),
        .offset_o    (new_offset)
    );

    agc_status_slave u_status_slave (
        .wb_clk_i   (wb_clk_i),
        .arst_n_i   (arst_n_i),
        .host_req_i (host_req_i),
        .host_rsp_o (host_rsp_o),
        .rd_idx_o   (rd_idx),
        .rd_dat_i   (rd_dat)
    );

endmodule

//--- rtl/agc_status_slave.sv
`timescale 1ns/1ps

module agc_status_slave (
    input  logic                 wb_clk_i,
    input  logic                 arst_n_i,
    input  agc_bus_pkg::wb_req_t host_req_i,
    output agc_bus_pkg::wb_rsp_t host_rsp_o,
    output logic [3:0]           rd_idx_o,
    input  logic [31:0]          rd_dat_i
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        ACK
    } slv_state_e;

    slv_state_e  state_q;
    logic [31:0] resp_q;
    logic [31:0] step_word;

    assign rd_idx_o = host_req_i.adr[3:0];

    // Loop step sizes, seen when address bit 4 is set
    always_comb begin
        case (host_req_i.adr[3:0])
            4'h0:    step_word = {15'b0, agc_loop_pkg::SCALE_STEP};
            4'h1:    step_word = {{16{agc_loop_pkg::OFFSET_STEP[15]}}, agc_loop_pkg::OFFSET_STEP};
            default: step_word = '0;
        endcase
    end

    ////////////////////////////////////////
    // Target FSM
    ////////////////////////////////////////
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (host_req_i.cyc && host_req_i.stb)
                        state_q <= host_req_i.we ? WRITE : READ;
                end
                READ:    state_q <= ACK;
                WRITE:   state_q <= ACK;    // Nothing writable yet
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state_q == READ) resp_q <= host_req_i.adr[4] ? step_word : rd_dat_i;
    end

    assign host_rsp_o.ack = (state_q == ACK);
    assign host_rsp_o.dat = resp_q;

    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        host_rsp_o.ack |=> !host_rsp_o.ack);

endmodule

//--- rtl/agc_step_calc.sv
`timescale 1ns/1ps

module agc_step_calc (
    input  logic                      wb_clk_i,
    input  logic                      arst_n_i,
    input  logic                      calc_i,
    input  agc_loop_pkg::info_words_t info_i,
    input  agc_loop_pkg::power_adj_t  power_adj_i,
    output agc_loop_pkg::scale_t      scale_o,
    output agc_loop_pkg::offset_t     offset_o
);

    agc_loop_pkg::scale_t  scale_q;
    agc_loop_pkg::scale_t  scale_d;
    agc_loop_pkg::offset_t offset_q;
    agc_loop_pkg::offset_t offset_d;
    agc_loop_pkg::scale_t  cur_scale;
    agc_loop_pkg::offset_t cur_offset;
    logic [31:0]           above;
    logic [31:0]           below;

    // Values the block reported as currently applied
    assign cur_scale  = agc_loop_pkg::scale_t'(info_i[agc_loop_pkg::INFO_SCALE]);
    assign cur_offset = agc_loop_pkg::offset_t'(info_i[agc_loop_pkg::INFO_OFFSET]);
    assign above      = info_i[agc_loop_pkg::INFO_ABOVE];
    assign below      = info_i[agc_loop_pkg::INFO_BELOW];

    ////////////////////////////////////////
    // Fixed step update
    ////////////////////////////////////////
    always_comb begin
        scale_d  = scale_q;
        offset_d = offset_q;

        if (power_adj_i > agc_loop_pkg::TARGET_POWER + agc_loop_pkg::POWER_TOL)
            scale_d = cur_scale - agc_loop_pkg::SCALE_STEP;     // Too loud
        else if (power_adj_i < agc_loop_pkg::TARGET_POWER - agc_loop_pkg::POWER_TOL)
            scale_d = cur_scale + agc_loop_pkg::SCALE_STEP;     // Too quiet

        // Balance samples around zero
        if (above > below + agc_loop_pkg::OFFSET_TOL)
            offset_d = cur_offset - agc_loop_pkg::OFFSET_STEP;
        else if (below > above + agc_loop_pkg::OFFSET_TOL)
            offset_d = cur_offset + agc_loop_pkg::OFFSET_STEP;
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            scale_q  <= agc_loop_pkg::START_SCALE;
            offset_q <= agc_loop_pkg::START_OFFSET;
        end else if (calc_i) begin
            scale_q  <= scale_d;
            offset_q <= offset_d;
        end
    end

    assign scale_o  = scale_q;
    assign offset_o = offset_q;

endmodule

//--- rtl/agc_info_regs.sv
`timescale 1ns/1ps

module agc_info_regs (
    input  logic                      wb_clk_i,
    input  logic                      arst_n_i,
    input  logic                      info_we_i,
    input  agc_loop_pkg::info_idx_t   info_idx_i,
    input  logic [31:0]               info_dat_i,
    input  logic                      commit_i,
    input  agc_loop_pkg::scale_t      scale_i,
    input  agc_loop_pkg::offset_t     offset_i,
    input  logic [3:0]                rd_idx_i,
    output logic [31:0]               rd_dat_o,
    output agc_loop_pkg::info_words_t info_o,
    output agc_loop_pkg::power_adj_t  power_adj_o
);

    agc_loop_pkg::info_words_t info_q;

    ////////////////////////////////////////
    // Status store
    ////////////////////////////////////////
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            info_q <= '0;
        end else begin
            if (info_we_i) info_q[info_idx_i] <= info_dat_i;
            // Applied values become the reference for the next step
            if (commit_i) begin
                info_q[agc_loop_pkg::INFO_SCALE]  <= {15'b0, scale_i};
                info_q[agc_loop_pkg::INFO_OFFSET] <= {{16{offset_i[15]}}, offset_i};
            end
        end
    end

    assign info_o = info_q;

    // Power reduced to the measurement window
    assign power_adj_o = info_q[agc_loop_pkg::INFO_POWER][24:agc_loop_pkg::POWER_SHIFT];

    // Host read port, unused indices read as zero
    assign rd_dat_o = (rd_idx_i < 4'(agc_loop_pkg::NUM_INFO)) ? info_q[rd_idx_i[2:0]] : '0;

    a_idx_range: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        info_we_i |-> (info_idx_i < 3'(agc_loop_pkg::NUM_INFO)));

endmodule

//--- rtl/agc_loop_sequencer.sv
`timescale 1ns/1ps

module agc_loop_sequencer (
    input  logic                    wb_clk_i,
    input  logic                    arst_n_i,
    output agc_bus_pkg::wb_req_t    agc_req_o,
    input  agc_bus_pkg::wb_rsp_t    agc_rsp_i,
    output logic                    info_we_o,
    output agc_loop_pkg::info_idx_t info_idx_o,
    output logic [31:0]             info_dat_o,
    output logic                    calc_o,
    output logic                    commit_o,
    input  agc_loop_pkg::scale_t    new_scale_i,
    input  agc_loop_pkg::offset_t   new_offset_i
);

    // Sub-phase of one bus transaction
    typedef enum logic [1:0] {
        PH_SEND,
        PH_WAIT,
        PH_PROC
    } phase_e;

    agc_loop_pkg::seq_state_e state_q;
    phase_e                   phase_q;
    logic [4:0]               boot_cnt_q;
    agc_loop_pkg::info_idx_t  rd_idx_q;     // Status word being read
    logic                     wr_idx_q;     // 0 scale, 1 offset
    agc_bus_pkg::wb_req_t     req_q;
    logic [31:0]              rsp_q;        // Last read data

    logic        cmd_we;
    logic [7:0]  cmd_adr;
    logic [31:0] cmd_dat;
    logic        ack_seen;

    assign ack_seen = (phase_q == PH_WAIT) && agc_rsp_i.ack;

    ////////////////////////////////////////
    // Request contents per state
    ////////////////////////////////////////
    always_comb begin
        cmd_we  = 1'b1;
        cmd_adr = agc_bus_pkg::ADR_CTRL;
        cmd_dat = '0;
        case (state_q)
            agc_loop_pkg::RESETTING: cmd_dat = agc_bus_pkg::CMD_RESET;
            agc_loop_pkg::STARTING:  cmd_dat = agc_bus_pkg::CMD_START;
            agc_loop_pkg::POLLING:   cmd_we  = 1'b0;
            agc_loop_pkg::READING: begin
                cmd_we  = 1'b0;
                cmd_adr = {3'b000, rd_idx_q, 2'b00};
            end
            agc_loop_pkg::WRITING: begin
                if (!wr_idx_q) begin
                    cmd_adr = agc_bus_pkg::ADR_SCALE;
                    cmd_dat = {15'b0, new_scale_i};              // Zero extended
                end else begin
                    cmd_adr = agc_bus_pkg::ADR_SCALE + 8'd4;
                    cmd_dat = {{16{new_offset_i[15]}}, new_offset_i}; // Sign extended
                end
            end
            agc_loop_pkg::LOADING:   cmd_dat = agc_bus_pkg::CMD_LOAD;
            agc_loop_pkg::APPLYING:  cmd_dat = agc_bus_pkg::CMD_APPLY;
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Loop FSM
    ////////////////////////////////////////
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= agc_loop_pkg::BOOT;
            phase_q    <= PH_SEND;
            boot_cnt_q <= 5'(agc_loop_pkg::BOOT_CYCLES);
            rd_idx_q   <= '0;
            wr_idx_q   <= 1'b0;
            req_q      <= '0;
        end else if (state_q == agc_loop_pkg::BOOT) begin
            if (boot_cnt_q != '0) boot_cnt_q <= boot_cnt_q - 5'd1;
            else state_q <= agc_loop_pkg::WRITING;     // Push starting values first
        end else if (state_q == agc_loop_pkg::CALCULATING) begin
            state_q <= agc_loop_pkg::WRITING;
        end else begin
            case (phase_q)
                PH_SEND: begin
                    req_q <= '{cyc: 1'b1, stb: 1'b1, we: cmd_we, adr: cmd_adr,
                               dat: cmd_dat, sel: 4'hf};
                    phase_q <= PH_WAIT;
                end
                PH_WAIT: begin
                    if (agc_rsp_i.ack) begin
                        req_q <= '0;
                        if (!req_q.we) begin
                            phase_q <= PH_PROC;         // Look at the read data next
                        end else begin
                            phase_q <= PH_SEND;
                            case (state_q)
                                agc_loop_pkg::RESETTING: state_q <= agc_loop_pkg::STARTING;
                                agc_loop_pkg::STARTING:  state_q <= agc_loop_pkg::POLLING;
                                agc_loop_pkg::WRITING: begin
                                    wr_idx_q <= ~wr_idx_q;
                                    if (wr_idx_q) state_q <= agc_loop_pkg::LOADING;
                                end
                                agc_loop_pkg::LOADING:   state_q <= agc_loop_pkg::APPLYING;
                                default:                 state_q <= agc_loop_pkg::RESETTING;
                            endcase
                        end
                    end
                end
                default: begin
                    phase_q <= PH_SEND;
                    if (state_q == agc_loop_pkg::POLLING) begin
                        // Keep polling until the measurement reports done
                        if (rsp_q[agc_bus_pkg::STATUS_DONE_BIT]) begin
                            state_q  <= agc_loop_pkg::READING;
                            rd_idx_q <= '0;
                        end
                    end else if (rd_idx_q ==
                                 agc_loop_pkg::info_idx_t'(agc_loop_pkg::NUM_INFO - 1)) begin
                        state_q  <= agc_loop_pkg::CALCULATING;
                        rd_idx_q <= '0;
                    end else begin
                        rd_idx_q <= rd_idx_q + 3'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (ack_seen && !req_q.we) rsp_q <= agc_rsp_i.dat;
    end

    assign agc_req_o  = req_q;
    assign info_we_o  = (state_q == agc_loop_pkg::READING) && (phase_q == PH_PROC);
    assign info_idx_o = rd_idx_q;
    assign info_dat_o = rsp_q;
    assign calc_o     = (state_q == agc_loop_pkg::CALCULATING);
    assign commit_o   = (state_q == agc_loop_pkg::APPLYING) && ack_seen;

    // A pending request must not change until the target acks it
    a_req_stable: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        req_q.cyc && !agc_rsp_i.ack |=> $stable(req_q));

    a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        $rose(agc_req_o.stb) |-> agc_req_o.cyc);

endmodule

//--- rtl/agc_loop_pkg.sv
// Constants and types of the gain control loop itself

package agc_loop_pkg;

    ////////////////////////////////////////
    // Word types
    ////////////////////////////////////////

    typedef logic        [16:0] scale_t;
    typedef logic signed [15:0] offset_t;
    typedef logic        [2:0]  info_idx_t;

    // Status words read back from the AGC block
    localparam info_idx_t INFO_STATUS = 3'd0;
    localparam info_idx_t INFO_POWER  = 3'd1;   // Sum of squares
    localparam info_idx_t INFO_ABOVE  = 3'd2;   // Samples above zero
    localparam info_idx_t INFO_BELOW  = 3'd3;   // Samples below zero
    localparam info_idx_t INFO_SCALE  = 3'd4;
    localparam info_idx_t INFO_OFFSET = 3'd5;

    localparam int NUM_INFO = 6;

    typedef logic [31:0] word_t;
    typedef word_t [NUM_INFO-1:0] info_words_t;

    ////////////////////////////////////////
    // Loop constants
    ////////////////////////////////////////

    localparam scale_t  START_SCALE  = 17'd1800;
    localparam offset_t START_OFFSET = 16'sd0;

    localparam scale_t  SCALE_STEP  = 17'd30;
    localparam offset_t OFFSET_STEP = 16'sd25;

    localparam int unsigned TARGET_POWER = 16;
    localparam int unsigned POWER_TOL    = 0;
    localparam int unsigned OFFSET_TOL   = 5;

    // Power word is shortened to the measurement timescale
    localparam int TIMESCALE_BITS = 4;
    localparam int POWER_SHIFT    = 17 - TIMESCALE_BITS;

    typedef logic [24-POWER_SHIFT:0] power_adj_t;

    localparam int BOOT_CYCLES = 31;

    typedef enum logic [3:0] {
        BOOT,
        RESETTING,
        STARTING,
        POLLING,
        READING,
        CALCULATING,
        WRITING,
        LOADING,
        APPLYING
    } seq_state_e;

endpackage

//--- rtl/agc_bus_pkg.sv
// Bus types and the register map of the external AGC datapath block

package agc_bus_pkg;

    ////////////////////////////////////////
    // Bus structs
    ////////////////////////////////////////

    // Request from a bus master towards a target
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    // Response from the target back to the master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    ////////////////////////////////////////
    // AGC block register map
    ////////////////////////////////////////

    localparam logic [7:0] ADR_CTRL  = 8'h00;   // Command on write, status on read
    localparam logic [7:0] ADR_SCALE = 8'h10;   // Offset register follows at +4

    // Status word k lives at address 4*k

    localparam int STATUS_DONE_BIT = 1;         // Measurement finished flag

    // Commands written to ADR_CTRL
    typedef enum logic [31:0] {
        CMD_START = 32'h0000_0001,
        CMD_RESET = 32'h0000_0004,
        CMD_LOAD  = 32'h0000_0300,
        CMD_APPLY = 32'h0000_0400
    } agc_cmd_e;

endpackage
